//--- lsu_obi_subsys.f
hw/obi_bus_pkg.sv
hw/lsu_core_pkg.sv
hw/obi_data_if.sv
hw/lsu_issue.sv
hw/lsu_response_filter.sv
hw/lsu_load_align.sv
hw/lsu_obi_subsys.sv
verif/tb_clk_gen.sv
verif/tb_lsu_obi_subsys.sv

//--- Bender.yml
package:
  name: lsu_obi_subsys

sources:
  # Packages first, then interface and design units
  - hw/obi_bus_pkg.sv
  - hw/lsu_core_pkg.sv
  - hw/obi_data_if.sv
  - hw/lsu_issue.sv
  - hw/lsu_response_filter.sv
  - hw/lsu_load_align.sv
  - hw/lsu_obi_subsys.sv

  # Verification sources
  - target: test
    files:
      - verif/tb_clk_gen.sv
      - verif/tb_lsu_obi_subsys.sv

//--- verif/tb_lsu_obi_subsys.sv
`timescale 1ns/1ps

module tb_lsu_obi_subsys;
  import lsu_core_pkg::*;

  localparam logic [31:0] rng_seed       = 32'h8e37_3bd3;
  localparam int          num_ops        = 400;
  // Worst case per op plus slack for reset and drain
  localparam int          timeout_cycles = num_ops * 8 + 200;

  // Expected core response in acceptance order
  typedef struct packed {
    logic        bufferable;
    logic [31:0] rdata;
    logic        err;
  } core_exp_t;

  // Bus transfer waiting for its rvalid
  typedef struct packed {
    logic [31:0] ready_cyc;
    logic [31:0] rdata;
    logic        err;
    logic        bufferable;
  } bus_pend_t;

  logic        clk;
  logic        rst_n;
  logic        lsu_req_valid_i;
  lsu_op_e     lsu_op_i;
  lsu_size_e   lsu_size_i;
  logic        lsu_sign_ext_i;
  logic [31:0] lsu_addr_i;
  logic [31:0] lsu_wdata_i;
  logic        lsu_req_ready_o;
  logic        lsu_resp_valid_o;
  logic [31:0] lsu_rdata_o;
  logic        lsu_err_o;
  logic        lsu_busy_o;
  logic        store_err_o;
  logic        err_type_o;
  logic        bus_req_o;
  logic [31:0] bus_addr_o;
  logic        bus_we_o;
  logic [3:0]  bus_be_o;
  logic [31:0] bus_wdata_o;
  logic        bus_gnt_i;
  logic        bus_rvalid_i;
  logic [31:0] bus_rdata_i;
  logic        bus_err_i;

  // Model state
  core_exp_t   exp_q [$];
  bus_pend_t   bus_q [$];
  logic [31:0] bus_mem [logic [31:0]];
  logic [7:0]  mirror_mem [logic [31:0]];
  int          cyc;
  int          ops_sent;
  int          resp_cnt;
  int          outstanding;
  int          nb_resp_cnt;
  int          nb_rvalid_cnt;
  int          data_errs;
  int          proto_errs;
  logic [31:0] last_ready;
  logic        req_active;
  int unsigned seed_ret;

  tb_clk_gen #(
    .period_ns  (40),
    .rst_cycles (4)
  ) u_clk_gen (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  lsu_obi_subsys dut_i (
    .clk              (clk),
    .rst_n            (rst_n),
    .lsu_req_valid_i  (lsu_req_valid_i),
    .lsu_op_i         (lsu_op_i),
    .lsu_size_i       (lsu_size_i),
    .lsu_sign_ext_i   (lsu_sign_ext_i),
    .lsu_addr_i       (lsu_addr_i),
    .lsu_wdata_i      (lsu_wdata_i),
    .lsu_req_ready_o  (lsu_req_ready_o),
    .lsu_resp_valid_o (lsu_resp_valid_o),
    .lsu_rdata_o      (lsu_rdata_o),
    .lsu_err_o        (lsu_err_o),
    .lsu_busy_o       (lsu_busy_o),
    .store_err_o      (store_err_o),
    .err_type_o       (err_type_o),
    .bus_req_o        (bus_req_o),
    .bus_addr_o       (bus_addr_o),
    .bus_we_o         (bus_we_o),
    .bus_be_o         (bus_be_o),
    .bus_wdata_o      (bus_wdata_o),
    .bus_gnt_i        (bus_gnt_i),
    .bus_rvalid_i     (bus_rvalid_i),
    .bus_rdata_i      (bus_rdata_i),
    .bus_err_i        (bus_err_i)
  );

  ////////////////////////////////////////////////////////////
  // Reporting
  ////////////////////////////////////////////////////////////

  task automatic report_mismatch(input string what);
    data_errs++;
    $display("CHECK FAILED @ %0t: %s", $time, what);
  endtask

  task automatic report_violation(input string what);
    proto_errs++;
    $display("Error at %0t: %s", $time, what);
  endtask

  ////////////////////////////////////////////////////////////
  // Memories and reference rules
  ////////////////////////////////////////////////////////////

  // Never written words read as the rotated address folded with a constant
  function automatic logic [31:0] fill_word(input logic [31:0] waddr);
    return {waddr[15:0], waddr[31:16]} ^ 32'h5a5a_c3c3;
  endfunction

  // Two regions inside the bufferable window and two outside it
  function automatic logic [31:0] region_base(input int unsigned idx);
    case (idx)
      0:       return 32'h0000_1000;
      1:       return 32'h2000_0000;
      2:       return 32'h2fff_ffc0;
      default: return 32'h3000_0000;
    endcase
  endfunction

  function automatic logic [3:0] expected_be(input lsu_size_e size, input logic [1:0] ofs);
    case (size)
      size_byte: return 4'b0001 << ofs;
      size_half: return 4'b0011 << ofs;
      default:   return 4'b1111;
    endcase
  endfunction

  function automatic logic [31:0] bus_read(input logic [31:0] addr);
    logic [31:0] waddr;
    waddr = {addr[31:2], 2'b00};
    if (bus_mem.exists(waddr)) begin
      return bus_mem[waddr];
    end
    return fill_word(waddr);
  endfunction

  // Responder memory is written straight from the bus pins
  task automatic bus_write(input logic [31:0] addr, input logic [3:0] be,
                           input logic [31:0] wdata);
    logic [31:0] word;
    word = bus_read(addr);
    for (int i = 0; i < 4; i++) begin
      if (be[i]) begin
        word[8*i +: 8] = wdata[8*i +: 8];
      end
    end
    bus_mem[{addr[31:2], 2'b00}] = word;
  endtask

  // Mirror is byte addressed and little endian
  function automatic logic [7:0] mirror_byte(input logic [31:0] baddr);
    logic [31:0] word;
    word = fill_word({baddr[31:2], 2'b00});
    if (mirror_mem.exists(baddr)) begin
      return mirror_mem[baddr];
    end
    return word[8*baddr[1:0] +: 8];
  endfunction

  task automatic mirror_store(input logic [31:0] addr, input lsu_size_e size,
                              input logic [31:0] wdata);
    int nbytes;
    nbytes = 1 << size;
    for (int i = 0; i < nbytes; i++) begin
      mirror_mem[addr + i] = wdata[8*i +: 8];
    end
  endtask

  // Load result as the core should see it
  function automatic logic [31:0] model_load(input logic [31:0] addr, input lsu_size_e size,
                                             input logic sext);
    logic [31:0] val;
    int          nbytes;
    val    = '0;
    nbytes = 1 << size;
    for (int i = 0; i < nbytes; i++) begin
      val[8*i +: 8] = mirror_byte(addr + i);
    end
    if (sext && (nbytes < 4) && val[8*nbytes-1]) begin
      val = val | (32'hffff_ffff << (8 * nbytes));
    end
    return val;
  endfunction

  function automatic logic drained();
    return (ops_sent == num_ops) && !req_active && (exp_q.size() == 0) && (bus_q.size() == 0);
  endfunction

  ////////////////////////////////////////////////////////////
  // Stimulus driven just after the rising edge
  ////////////////////////////////////////////////////////////

  task automatic issue_core_cmd();
    logic [31:0] rnd;
    logic [1:0]  ofs;
    // A pending command is held until accepted
    if (!req_active) begin
      lsu_req_valid_i = 1'b0;
      if ((ops_sent < num_ops) && (($urandom % 4) != 0)) begin
        rnd            = $urandom;
        lsu_op_i       = lsu_op_e'(rnd[0]);
        lsu_sign_ext_i = rnd[1];
        lsu_size_i     = lsu_size_e'(2'($urandom % 3));
        ofs            = rnd[3:2];
        if (lsu_size_i == size_half) begin
          ofs[0] = 1'b0;
        end
        if (lsu_size_i == size_word) begin
          ofs = 2'b00;
        end
        lsu_addr_i      = region_base($urandom % 4) + (($urandom % 16) * 4) + ofs;
        lsu_wdata_i     = $urandom;
        lsu_req_valid_i = 1'b1;
        req_active      = 1'b1;
      end
    end
  endtask

  // Random grant and in-order rvalid once the head transfer is due
  task automatic answer_bus();
    bus_gnt_i    = (($urandom % 4) != 0);
    bus_rvalid_i = 1'b0;
    bus_rdata_i  = '0;
    bus_err_i    = 1'b0;
    if (bus_q.size() != 0) begin
      if (bus_q[0].ready_cyc <= cyc) begin
        bus_rvalid_i = 1'b1;
        bus_rdata_i  = bus_q[0].rdata;
        bus_err_i    = bus_q[0].err;
      end
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Checks at the falling edge where inputs and outputs have settled
  ////////////////////////////////////////////////////////////

  task automatic observe_cycle();
    core_exp_t   exp;
    bus_pend_t   pend;
    logic        accepted;
    logic        exp_store_err;
    logic        is_buf;
    logic        err;
    logic [31:0] ready;
    accepted = lsu_req_valid_i && lsu_req_ready_o;
    // Full bus side holds the core off
    if ((outstanding == lsu_depth) && lsu_req_ready_o) begin
      report_violation("core ready high while the bus already has the maximum open transfers");
    end
    if ((bus_req_o && bus_gnt_i) != accepted) begin
      report_violation("bus handshake and core handshake did not happen together");
    end

    // Core response against the oldest expected entry
    if (lsu_resp_valid_o) begin
      if (exp_q.size() == 0) begin
        report_violation("core response arrived with no request pending");
      end else begin
        exp = exp_q.pop_front();
        resp_cnt++;
        if (!exp.bufferable) begin
          nb_resp_cnt++;
        end
        if (lsu_rdata_o !== exp.rdata) begin
          report_mismatch($sformatf("rdata %h, expected %h", lsu_rdata_o, exp.rdata));
        end
        if (lsu_err_o !== exp.err) begin
          report_mismatch($sformatf("lsu_err_o %b, expected %b", lsu_err_o, exp.err));
        end
      end
    end

    // Bus rvalid retires the oldest open transfer
    exp_store_err = 1'b0;
    if (bus_rvalid_i) begin
      pend = bus_q.pop_front();
      outstanding--;
      if (!pend.bufferable) begin
        nb_rvalid_cnt++;
      end
      exp_store_err = pend.err && pend.bufferable;
    end
    if (store_err_o !== exp_store_err) begin
      report_mismatch($sformatf("store_err_o %b, expected %b", store_err_o, exp_store_err));
    end
    if (exp_store_err && (err_type_o !== 1'b1)) begin
      report_mismatch("err_type_o low on a buffered store error");
    end
    if (nb_resp_cnt > nb_rvalid_cnt) begin
      report_violation("load or ordered store answered to the core before its bus rvalid");
    end

    if (accepted) begin
      if ((bus_addr_o !== lsu_addr_i) || (bus_we_o !== (lsu_op_i == op_store))) begin
        report_mismatch($sformatf("bus addr %h we %b for core addr %h", bus_addr_o, bus_we_o,
                                  lsu_addr_i));
      end
      if (bus_be_o !== expected_be(lsu_size_i, lsu_addr_i[1:0])) begin
        report_mismatch($sformatf("bus_be_o %b at addr %h", bus_be_o, lsu_addr_i));
      end
      is_buf = (lsu_op_i == op_store) && (lsu_addr_i >= buf_base) && (lsu_addr_i <= buf_limit);
      err    = (($urandom % 16) == 0);
      // A failed store leaves memory untouched
      if (lsu_op_i == op_store) begin
        if (!err) begin
          bus_write(bus_addr_o, bus_be_o, bus_wdata_o);
          mirror_store(lsu_addr_i, lsu_size_i, lsu_wdata_i);
        end
        exp  = '{bufferable: is_buf, rdata: '0, err: err && !is_buf};
        pend = '{ready_cyc: '0, rdata: $urandom, err: err, bufferable: is_buf};
      end else begin
        exp  = '{bufferable: 1'b0, err: err,
                 rdata: model_load(lsu_addr_i, lsu_size_i, lsu_sign_ext_i)};
        pend = '{ready_cyc: '0, rdata: bus_read(bus_addr_o), err: err, bufferable: 1'b0};
      end
      // Delay of 1 to 4 cycles that never overtakes an older transfer
      ready = cyc + 1 + ($urandom % 4);
      if (ready <= last_ready) begin
        ready = last_ready + 1;
      end
      pend.ready_cyc = ready;
      last_ready     = ready;
      bus_q.push_back(pend);
      exp_q.push_back(exp);
      outstanding++;
      ops_sent++;
      req_active = 1'b0;
      if (outstanding > lsu_depth) begin
        report_violation("more bus transfers open than the allowed depth");
      end
    end
  endtask

  task automatic run_cycle();
    @(posedge clk);
    cyc++;
    #2;
    issue_core_cmd();
    answer_bus();
    @(negedge clk);
    observe_cycle();
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////

  initial begin
    seed_ret        = $urandom(rng_seed);
    lsu_req_valid_i = 1'b0;
    lsu_op_i        = op_load;
    lsu_size_i      = size_word;
    lsu_sign_ext_i  = 1'b0;
    lsu_addr_i      = '0;
    lsu_wdata_i     = '0;
    bus_gnt_i       = 1'b0;
    bus_rvalid_i    = 1'b0;
    bus_rdata_i     = '0;
    bus_err_i       = 1'b0;
    cyc             = 0;
    ops_sent        = 0;
    resp_cnt        = 0;
    outstanding     = 0;
    nb_resp_cnt     = 0;
    nb_rvalid_cnt   = 0;
    data_errs       = 0;
    proto_errs      = 0;
    last_ready      = '0;
    req_active      = 1'b0;

    wait (rst_n === 1'b1);
    @(negedge clk);
    if ((bus_req_o !== 1'b0) || (lsu_resp_valid_o !== 1'b0) || (store_err_o !== 1'b0) ||
        (lsu_busy_o !== 1'b0)) begin
      report_mismatch("outputs not idle after reset");
    end

    while (!drained() && (cyc < timeout_cycles)) begin
      run_cycle();
    end

    if (!drained()) begin
      report_violation($sformatf("timeout after %0d cycles with %0d of %0d operations accepted",
                                 cyc, ops_sent, num_ops));
    end else begin
      // Idle tail with nothing open where busy must drop
      repeat (2) run_cycle();
      if (lsu_busy_o !== 1'b0) begin
        report_mismatch("lsu_busy_o still high after all responses");
      end
      if (resp_cnt != num_ops) begin
        report_violation($sformatf("%0d core responses for %0d requests", resp_cnt, num_ops));
      end
    end

    $display("Errors: %0d value, %0d protocol, %0d responses over %0d cycles",
             data_errs, proto_errs, resp_cnt, cyc);
    if ((data_errs + proto_errs) == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

//--- verif/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int period_ns  = 40,
  parameter int rst_cycles = 4
) (
  output logic clk_o,
  output logic rst_n_o
);

  // Free running clock, starts low
  initial begin
    clk_o = 1'b0;
    forever #(period_ns / 2) clk_o = ~clk_o;
  end

  // Reset low for a fixed count of rising edges, released off the edge
  initial begin
    rst_n_o = 1'b0;
    repeat (rst_cycles) @(posedge clk_o);
    #2;
    rst_n_o = 1'b1;
  end

endmodule

//--- hw/lsu_obi_subsys.sv
`timescale 1ns/1ps

module lsu_obi_subsys (
  input  logic                               clk,
  input  logic                               rst_n,
  // Core command
  input  logic                               lsu_req_valid_i,
  input  lsu_core_pkg::lsu_op_e              lsu_op_i,
  input  lsu_core_pkg::lsu_size_e            lsu_size_i,
  input  logic                               lsu_sign_ext_i,
  input  logic [obi_bus_pkg::obi_addr_w-1:0] lsu_addr_i,
  input  logic [obi_bus_pkg::obi_data_w-1:0] lsu_wdata_i,
  output logic                               lsu_req_ready_o,
  // Core response
  output logic                               lsu_resp_valid_o,
  output logic [obi_bus_pkg::obi_data_w-1:0] lsu_rdata_o,
  output logic                               lsu_err_o,
  output logic                               lsu_busy_o,
  output logic                               store_err_o,
  output logic                               err_type_o,
  // OBI data bus
  output logic                               bus_req_o,
  output logic [obi_bus_pkg::obi_addr_w-1:0] bus_addr_o,
  output logic                               bus_we_o,
  output logic [obi_bus_pkg::obi_be_w-1:0]   bus_be_o,
  output logic [obi_bus_pkg::obi_data_w-1:0] bus_wdata_o,
  input  logic                               bus_gnt_i,
  input  logic                               bus_rvalid_i,
  input  logic [obi_bus_pkg::obi_data_w-1:0] bus_rdata_i,
  input  logic                               bus_err_i
);
  import obi_bus_pkg::*;
  import lsu_core_pkg::*;

  obi_data_req_t  bus_trans;
  obi_data_resp_t bus_resp;

  // Issue to filter, and filter response towards core and aligner
  obi_data_if core_side_if (.clk(clk));
  obi_data_if resp_if (.clk(clk));

  lsu_issue u_issue (
    .clk             (clk),
    .rst_n           (rst_n),
    .lsu_req_valid_i (lsu_req_valid_i),
    .lsu_op_i        (lsu_op_i),
    .lsu_size_i      (lsu_size_i),
    .lsu_addr_i      (lsu_addr_i),
    .lsu_wdata_i     (lsu_wdata_i),
    .lsu_req_ready_o (lsu_req_ready_o),
    .obi_o           (core_side_if.mgr)
  );

  lsu_response_filter #(
    .DEPTH (lsu_depth)
  ) u_filter (
    .clk          (clk),
    .rst_n        (rst_n),
    .core_i       (core_side_if.sub),
    .bus_req_o    (bus_req_o),
    .bus_trans_o  (bus_trans),
    .bus_gnt_i    (bus_gnt_i),
    .bus_rvalid_i (bus_rvalid_i),
    .bus_resp_i   (bus_resp),
    .resp_o       (resp_if.mgr),
    .busy_o       (lsu_busy_o),
    .store_err_o  (store_err_o),
    .err_type_o   (err_type_o)
  );

  lsu_load_align u_align (
    .clk            (clk),
    .rst_n          (rst_n),
    .issue_i        (core_side_if.mon),
    .resp_i         (resp_if.mon),
    .lsu_size_i     (lsu_size_i),
    .lsu_sign_ext_i (lsu_sign_ext_i),
    .lsu_rdata_o    (lsu_rdata_o),
    .lsu_err_o      (lsu_err_o)
  );

  assign lsu_resp_valid_o = resp_if.rvalid;

  // Flatten bus request, bufferable stays internal
  assign bus_addr_o  = bus_trans.addr;
  assign bus_we_o    = bus_trans.we;
  assign bus_be_o    = bus_trans.be;
  assign bus_wdata_o = bus_trans.wdata;
  assign bus_resp    = '{rdata: bus_rdata_i, err: bus_err_i};

endmodule

//--- hw/lsu_load_align.sv
`timescale 1ns/1ps

module lsu_load_align (
  input  logic                               clk,
  input  logic                               rst_n,
  obi_data_if.mon                            issue_i,
  obi_data_if.mon                            resp_i,
  input  lsu_core_pkg::lsu_size_e            lsu_size_i,
  input  logic                               lsu_sign_ext_i,
  output logic [obi_bus_pkg::obi_data_w-1:0] lsu_rdata_o,
  output logic                               lsu_err_o
);
  import lsu_core_pkg::*;

  localparam int unsigned ptr_w = (lsu_depth > 1) ? $clog2(lsu_depth) : 1;

  // One entry per core-side transfer, stores only hold the marker
  typedef struct packed {
    logic       is_store;
    logic       bufferable;
    lsu_size_e  size;
    logic       sign_ext;
    logic [1:0] offset;
  } load_attr_t;

  load_attr_t       attr_mem [lsu_depth];
  load_attr_t       head;
  logic [ptr_w-1:0] wr_ptr_q;
  logic [ptr_w-1:0] rd_ptr_q;
  logic             push;
  logic             pop;
  logic [31:0]      shifted;
  logic [31:0]      extended;

  // Written at core acceptance, read at core response
  assign push = issue_i.req && issue_i.gnt;
  assign pop  = resp_i.rvalid;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == ptr_w'(lsu_depth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == ptr_w'(lsu_depth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      attr_mem[wr_ptr_q] <= '{is_store:   issue_i.trans.we,
                              bufferable: issue_i.trans.bufferable,
                              size:       lsu_size_i,
                              sign_ext:   lsu_sign_ext_i,
                              offset:     issue_i.trans.addr[1:0]};
    end
  end

  assign head = attr_mem[rd_ptr_q];

  // Addressed byte lands in lane 0
  assign shifted = resp_i.resp.rdata >> {head.offset, 3'b000};

  always_comb begin
    case (head.size)
      size_byte: extended = {{24{head.sign_ext & shifted[7]}}, shifted[7:0]};
      size_half: extended = {{16{head.sign_ext & shifted[15]}}, shifted[15:0]};
      default:   extended = shifted;
    endcase
  end

  assign lsu_rdata_o = head.is_store ? '0 : extended;
  // Buffered store errors are reported through store_err_o instead
  assign lsu_err_o   = resp_i.resp.err && !head.bufferable;

endmodule

//--- hw/lsu_response_filter.sv
`timescale 1ns/1ps

module lsu_response_filter #(
  parameter int unsigned DEPTH = 2
) (
  input  logic                        clk,
  input  logic                        rst_n,
  obi_data_if.sub                     core_i,
  output logic                        bus_req_o,
  output obi_bus_pkg::obi_data_req_t  bus_trans_o,
  input  logic                        bus_gnt_i,
  input  logic                        bus_rvalid_i,
  input  obi_bus_pkg::obi_data_resp_t bus_resp_i,
  obi_data_if.mgr                     resp_o,
  output logic                        busy_o,
  output logic                        store_err_o,
  output logic                        err_type_o
);
  import obi_bus_pkg::*;

  localparam int unsigned cnt_w = $clog2(DEPTH + 1);

  // Transfers open towards the bus
  logic [cnt_w-1:0] bus_cnt_q;
  logic [cnt_w-1:0] bus_cnt_d;
  // Transfers the core still waits on
  logic [cnt_w-1:0] core_cnt_q;
  logic [cnt_w-1:0] core_cnt_d;

  logic             has_room;
  logic             core_accept;
  logic             bus_accept;
  logic             bus_oldest_buf;
  logic             core_oldest_buf;
  logic             core_resp_valid;

  // Newest entry at index 1, oldest at index count
  // Index 0 stays zero so an empty side reads non-bufferable
  outstanding_t [DEPTH:0] outstanding_q;
  outstanding_t [DEPTH:0] outstanding_d;

  ////////////////////////////////////////////////////////////
  // Request pass-through with depth limit
  ////////////////////////////////////////////////////////////

  assign has_room    = (bus_cnt_q < cnt_w'(DEPTH));
  assign bus_req_o   = core_i.req && has_room;
  assign bus_trans_o = core_i.trans;
  // Core request is just held while full
  assign core_i.gnt  = bus_gnt_i && has_room;

  // Both handshakes share one gate so they fire together
  assign core_accept = core_i.req && core_i.gnt;
  assign bus_accept  = bus_req_o && bus_gnt_i;

  ////////////////////////////////////////////////////////////
  // Counters and attribute shift register
  ////////////////////////////////////////////////////////////

  assign bus_cnt_d  = bus_cnt_q + cnt_w'(bus_accept) - cnt_w'(bus_rvalid_i);
  assign core_cnt_d = core_cnt_q + cnt_w'(core_accept) - cnt_w'(core_resp_valid);

  always_comb begin
    outstanding_d = outstanding_q;
    if (bus_accept) begin
      outstanding_d[DEPTH:1] = outstanding_q[DEPTH-1:0];
      outstanding_d[1]       = '{bufferable: core_i.trans.bufferable,
                                 store:      core_i.trans.we};
      outstanding_d[0]       = '0;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      bus_cnt_q     <= '0;
      core_cnt_q    <= '0;
      outstanding_q <= '0;
    end else begin
      bus_cnt_q     <= bus_cnt_d;
      core_cnt_q    <= core_cnt_d;
      outstanding_q <= outstanding_d;
    end
  end

  ////////////////////////////////////////////////////////////
  // Response selection
  ////////////////////////////////////////////////////////////

  assign bus_oldest_buf  = outstanding_q[bus_cnt_q].bufferable;
  assign core_oldest_buf = outstanding_q[core_cnt_q].bufferable;

  // Bus busy with a buffered store, so its rvalid is swallowed
  // and the core side may complete its own buffered stores
  // Otherwise bus rvalid goes straight to the core
  assign core_resp_valid = bus_oldest_buf ? core_oldest_buf : bus_rvalid_i;

  // Response channel only, request fields idle
  assign resp_o.req    = 1'b0;
  assign resp_o.trans  = '0;
  assign resp_o.rvalid = core_resp_valid;
  assign resp_o.resp   = bus_resp_i;

  assign busy_o = (bus_cnt_q != '0) || core_i.req;

  // Imprecise error, the core already retired this store
  assign store_err_o = bus_rvalid_i && bus_resp_i.err && bus_oldest_buf;
  assign err_type_o  = outstanding_q[bus_cnt_q].store;

  // Core never tracks more than the bus has open
  a_cnt_bound: assert property (@(posedge clk) disable iff (!rst_n)
    (bus_cnt_q <= cnt_w'(DEPTH)) && (core_cnt_q <= bus_cnt_q));

  a_core_no_underflow: assert property (@(posedge clk) disable iff (!rst_n)
    core_resp_valid |-> (core_cnt_q != '0));

  a_rvalid_outstanding: assert property (@(posedge clk) disable iff (!rst_n)
    bus_rvalid_i |-> (bus_cnt_q != '0));

endmodule

//--- hw/lsu_issue.sv
`timescale 1ns/1ps

module lsu_issue (
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic                               lsu_req_valid_i,
  input  lsu_core_pkg::lsu_op_e              lsu_op_i,
  input  lsu_core_pkg::lsu_size_e            lsu_size_i,
  input  logic [obi_bus_pkg::obi_addr_w-1:0] lsu_addr_i,
  input  logic [obi_bus_pkg::obi_data_w-1:0] lsu_wdata_i,
  output logic                               lsu_req_ready_o,
  obi_data_if.mgr                            obi_o
);
  import lsu_core_pkg::*;

  logic        is_store;
  logic        in_buf_window;
  logic [3:0]  byte_en;
  logic [31:0] wdata_lanes;
  logic        aligned;

  ////////////////////////////////////////////////////////////
  // Attribute decode
  ////////////////////////////////////////////////////////////

  assign is_store      = (lsu_op_i == op_store);
  // Single fixed window, everything else is strongly ordered
  assign in_buf_window = (lsu_addr_i >= buf_base) && (lsu_addr_i <= buf_limit);

  ////////////////////////////////////////////////////////////
  // Byte enables and lane steering
  ////////////////////////////////////////////////////////////

  always_comb begin
    byte_en     = 4'b1111;
    wdata_lanes = lsu_wdata_i;
    case (lsu_size_i)
      size_byte: begin
        byte_en     = 4'b0001 << lsu_addr_i[1:0];
        // Copy into every lane, the enables pick the live one
        wdata_lanes = {4{lsu_wdata_i[7:0]}};
      end
      size_half: begin
        byte_en     = lsu_addr_i[1] ? 4'b1100 : 4'b0011;
        wdata_lanes = {2{lsu_wdata_i[15:0]}};
      end
      default: begin
        byte_en     = 4'b1111;
      end
    endcase
  end

  // Natural alignment per size
  always_comb begin
    case (lsu_size_i)
      size_byte: aligned = 1'b1;
      size_half: aligned = ~lsu_addr_i[0];
      size_word: aligned = (lsu_addr_i[1:0] == 2'b00);
      default:   aligned = 1'b0;
    endcase
  end

  // Command goes out in the same cycle
  assign obi_o.req   = lsu_req_valid_i;
  assign obi_o.trans = '{
    addr:       lsu_addr_i,
    we:         is_store,
    be:         byte_en,
    wdata:      wdata_lanes,
    bufferable: is_store && in_buf_window
  };

  // Ready already carries the filter's depth gating
  assign lsu_req_ready_o = obi_o.gnt;

  // Core only hands over naturally aligned accesses
  a_aligned_accept: assert property (@(posedge clk) disable iff (!rst_n)
    (obi_o.req && obi_o.gnt) |-> aligned)
    else $error("misaligned access accepted, addr %h", lsu_addr_i);

endmodule

//--- hw/obi_data_if.sv
`timescale 1ns/1ps

interface obi_data_if (
  input logic clk
);
  import obi_bus_pkg::*;

  // Request channel
  logic           req;
  logic           gnt;
  obi_data_req_t  trans;

  // Response channel, never back-pressured
  logic           rvalid;
  obi_data_resp_t resp;

  // Producer side, drives request and response fields of its stream
  modport mgr (
    input  clk,
    input  gnt,
    output req,
    output trans,
    output rvalid,
    output resp
  );

  // Request acceptor
  modport sub (
    input  clk,
    input  req,
    input  trans,
    output gnt
  );

  // Passive observer of both phases
  modport mon (
    input clk,
    input req,
    input gnt,
    input trans,
    input rvalid,
    input resp
  );

endinterface

//--- hw/lsu_core_pkg.sv
package lsu_core_pkg;

  ////////////////////////////////////////////////////////////
  // Core command encodings
  ////////////////////////////////////////////////////////////

  // Direction of a core data access
  typedef enum logic {
    op_load  = 1'b0,
    op_store = 1'b1
  } lsu_op_e;

  // Access size, encoding 2'b11 is never issued
  typedef enum logic [1:0] {
    size_byte = 2'b00,
    size_half = 2'b01,
    size_word = 2'b10
  } lsu_size_e;

  ////////////////////////////////////////////////////////////
  // Attribute map and sizing
  ////////////////////////////////////////////////////////////

  // Bufferable window, bounds inclusive
  localparam logic [31:0] buf_base  = 32'h2000_0000;
  localparam logic [31:0] buf_limit = 32'h2FFF_FFFF;

  // Max transfers open on the bus at once
  localparam int unsigned lsu_depth = 2;

endpackage

//--- hw/obi_bus_pkg.sv
package obi_bus_pkg;

  ////////////////////////////////////////////////////////////
  // Bus widths
  ////////////////////////////////////////////////////////////

  localparam int unsigned obi_addr_w = 32;
  localparam int unsigned obi_data_w = 32;
  // One enable per byte lane
  localparam int unsigned obi_be_w   = obi_data_w / 8;

  ////////////////////////////////////////////////////////////
  // Transfer types
  ////////////////////////////////////////////////////////////

  // Request phase of one data transfer
  typedef struct packed {
    logic [obi_addr_w-1:0] addr;
    logic                  we;
    logic [obi_be_w-1:0]   be;
    logic [obi_data_w-1:0] wdata;
    // Store that may be completed towards the core before the bus answers
    logic                  bufferable;
  } obi_data_req_t;

  // Response phase, returned in order with rvalid
  typedef struct packed {
    logic [obi_data_w-1:0] rdata;
    logic                  err;
  } obi_data_resp_t;

  // Attributes kept per transfer still open on the bus
  typedef struct packed {
    logic bufferable;
    logic store;
  } outstanding_t;

endpackage
